// File: lsu_pkg.sv
package lsu_pkg;

    localparam int ROB_TAG_BITS = 5;
    localparam int PREG_BITS = 6;

    // default sizes, overridden from lsu_top
    localparam int MEM_QUEUE_DEPTH = 8;
    localparam int MEM_WORDS = 256;

    typedef logic [31:0] word_t;
    typedef logic [ROB_TAG_BITS-1:0] rob_tag_t;
    typedef logic [PREG_BITS-1:0] preg_t;
    typedef logic [2:0] funct3_t;
    typedef logic [3:0] mask_t;

    // load funct3
    localparam funct3_t f3_lb = 3'b000;
    localparam funct3_t f3_lh = 3'b001;
    localparam funct3_t f3_lw = 3'b010;
    localparam funct3_t f3_lbu = 3'b100;
    localparam funct3_t f3_lhu = 3'b101;

    // store funct3
    localparam funct3_t f3_sb = 3'b000;
    localparam funct3_t f3_sh = 3'b001;
    localparam funct3_t f3_sw = 3'b010;

    // life of one queue slot
    typedef enum logic [1:0] {
        st_empty,
        st_wait_addr,
        st_ready,
        st_in_flight
    } entry_state_t;

endpackage

// File: agu.sv
`timescale 1ns/1ps

module agu
    import lsu_pkg::*;
#(
    parameter int QUEUE_DEPTH = MEM_QUEUE_DEPTH,
    localparam int IDX_BITS = $clog2(QUEUE_DEPTH)
) (
    input  logic                clk,
    input  logic                rst,

    input  logic                agu_valid,
    input  logic [IDX_BITS-1:0] agu_idx,
    input  word_t               agu_base,
    input  word_t               agu_offset,
    input  word_t               agu_wdata,

    output logic                addr_valid,
    output logic [IDX_BITS-1:0] addr_idx,
    output word_t               addr,
    output word_t               addr_wdata
);

    word_t sum;

    assign sum = agu_base + agu_offset;

    always_ff @(posedge clk) begin
        if (rst) begin
            addr_valid <= 1'b0;
        end else begin
            addr_valid <= agu_valid;
        end
    end

    // payload follows the request, qualified by addr_valid
    always_ff @(posedge clk) begin
        if (agu_valid) begin
            addr_idx <= agu_idx;
            addr <= sum;
            addr_wdata <= agu_wdata;
        end
    end

    // an X here would corrupt a random queue slot
    a_addr_valid_known: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(addr_valid)
    );

endmodule

// File: memory_queue.sv
`timescale 1ns/1ps

module memory_queue
    import lsu_pkg::*;
#(
    parameter int QUEUE_DEPTH = MEM_QUEUE_DEPTH,
    localparam int IDX_BITS = $clog2(QUEUE_DEPTH)
) (
    input  logic                clk,
    input  logic                rst,

    // dispatch
    input  logic                disp_valid,
    output logic                disp_ready,
    input  logic                disp_is_store,
    input  funct3_t             disp_funct3,
    input  rob_tag_t            disp_rob,
    input  preg_t               disp_pd,
    output logic [IDX_BITS-1:0] disp_idx,

    // address update from agu
    input  logic                addr_valid,
    input  logic [IDX_BITS-1:0] addr_idx,
    input  word_t               addr,
    input  word_t               addr_wdata,

    // commit
    input  logic                commit_valid,
    input  rob_tag_t            commit_rob,

    // data memory
    output logic                req_valid,
    output word_t               req_addr,
    output mask_t               req_rmask,
    output mask_t               req_wmask,
    output word_t               req_wdata,
    input  logic                rsp_valid,

    // completion handoff
    input  logic                out_ready,
    output logic                done_valid,
    output rob_tag_t            done_rob,
    output preg_t               done_pd,
    output logic                done_is_store,
    output funct3_t             done_funct3,
    output logic [1:0]          done_offset
);

    logic [IDX_BITS:0] head;
    logic [IDX_BITS:0] tail;
    logic [IDX_BITS-1:0] head_idx;
    logic [IDX_BITS-1:0] tail_idx;

    entry_state_t q_state [QUEUE_DEPTH];
    logic q_is_store [QUEUE_DEPTH];
    funct3_t q_funct3 [QUEUE_DEPTH];
    rob_tag_t q_rob [QUEUE_DEPTH];
    preg_t q_pd [QUEUE_DEPTH];
    word_t q_addr [QUEUE_DEPTH];
    word_t q_wdata [QUEUE_DEPTH];

    logic full;
    logic push;
    logic pop;
    logic issue;
    logic in_flight;
    logic rst_done;
    mask_t size_mask;
    logic [1:0] head_offset;

    assign head_idx = head[IDX_BITS-1:0];
    assign tail_idx = tail[IDX_BITS-1:0];
    assign full = (head_idx == tail_idx) && (head[IDX_BITS] != tail[IDX_BITS]);

    // a full queue still takes an op when the head leaves this cycle
    assign pop = rsp_valid;
    assign disp_ready = rst_done && (!full || pop);
    assign push = disp_valid && disp_ready;
    assign disp_idx = tail_idx;

    assign issue = (q_state[head_idx] == st_ready) && commit_valid
                   && (commit_rob == q_rob[head_idx]) && !in_flight && out_ready;

    assign head_offset = q_addr[head_idx][1:0];

    always_comb begin
        if (q_is_store[head_idx]) begin
            unique case (q_funct3[head_idx])
                f3_sb: size_mask = 4'b0001;
                f3_sh: size_mask = 4'b0011;
                default: size_mask = 4'b1111;
            endcase
        end else begin
            unique case (q_funct3[head_idx])
                f3_lb, f3_lbu: size_mask = 4'b0001;
                f3_lh, f3_lhu: size_mask = 4'b0011;
                default: size_mask = 4'b1111;
            endcase
        end
    end

    assign req_valid = issue;
    assign req_addr = {q_addr[head_idx][31:2], 2'b00};
    assign req_rmask = q_is_store[head_idx] ? 4'b0000 : mask_t'(size_mask << head_offset);
    assign req_wmask = q_is_store[head_idx] ? mask_t'(size_mask << head_offset) : 4'b0000;
    assign req_wdata = q_wdata[head_idx] << {head_offset, 3'b000};

    // head leaves together with the memory response
    assign done_valid = rsp_valid;
    assign done_rob = q_rob[head_idx];
    assign done_pd = q_pd[head_idx];
    assign done_is_store = q_is_store[head_idx];
    assign done_funct3 = q_funct3[head_idx];
    assign done_offset = head_offset;

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            in_flight <= 1'b0;
            rst_done <= 1'b0;
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                q_state[i] <= st_empty;
            end
        end else begin
            rst_done <= 1'b1;
            if (pop) begin
                q_state[head_idx] <= st_empty;
                head <= head + 1'b1;
                in_flight <= 1'b0;
            end
            if (issue) begin
                q_state[head_idx] <= st_in_flight;
                in_flight <= 1'b1;
            end
            if (addr_valid) begin
                q_state[addr_idx] <= st_ready;
            end
            // last, so a push into the slot just popped wins
            if (push) begin
                q_state[tail_idx] <= st_wait_addr;
                tail <= tail + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            q_is_store[tail_idx] <= disp_is_store;
            q_funct3[tail_idx] <= disp_funct3;
            q_rob[tail_idx] <= disp_rob;
            q_pd[tail_idx] <= disp_pd;
        end
        if (addr_valid) begin
            q_addr[addr_idx] <= addr;
            q_wdata[addr_idx] <= addr_wdata;
        end
    end

    a_addr_to_live_slot: assert property (
        @(posedge clk) disable iff (rst)
        addr_valid |-> q_state[addr_idx] != st_empty
    );

    // data_mem answers only what this queue asked for
    a_rsp_in_flight: assert property (
        @(posedge clk) disable iff (rst)
        rsp_valid |-> in_flight
    );

endmodule

// File: data_mem.sv
`timescale 1ns/1ps

module data_mem
    import lsu_pkg::*;
#(
    parameter int MEM_WORDS = lsu_pkg::MEM_WORDS,
    localparam int WIDX_BITS = $clog2(MEM_WORDS)
) (
    input  logic  clk,
    input  logic  rst,

    input  logic  req_valid,
    input  word_t req_addr,
    input  mask_t req_rmask,
    input  mask_t req_wmask,
    input  word_t req_wdata,

    output logic  rsp_valid,
    output word_t rsp_rdata
);

    word_t mem [MEM_WORDS];
    logic [WIDX_BITS-1:0] widx;

    // byte address to word index
    assign widx = req_addr[2 +: WIDX_BITS];

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            rsp_valid <= req_valid;
            if (req_valid) begin
                for (int b = 0; b < 4; b++) begin
                    if (req_wmask[b]) begin
                        mem[widx][8*b +: 8] <= req_wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    // lanes outside the read mask come back as zero
    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            rsp_rdata[8*b +: 8] <= req_rmask[b] ? mem[widx][8*b +: 8] : 8'h00;
        end
    end

endmodule

// File: load_align.sv
`timescale 1ns/1ps

module load_align
    import lsu_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  logic       done_valid,
    input  rob_tag_t   done_rob,
    input  preg_t      done_pd,
    input  logic       done_is_store,
    input  funct3_t    done_funct3,
    input  logic [1:0] done_offset,
    input  word_t      rsp_rdata,
    output logic       out_ready,

    output logic       cdb_valid,
    input  logic       cdb_ready,
    output rob_tag_t   cdb_rob,
    output preg_t      cdb_pd,
    output word_t      cdb_data,
    output logic       cdb_is_store
);

    word_t shifted;
    word_t result;
    logic load_en;

    assign shifted = rsp_rdata >> {done_offset, 3'b000};

    always_comb begin
        if (done_is_store) begin
            result = '0;
        end else begin
            unique case (done_funct3)
                f3_lb: result = {{24{shifted[7]}}, shifted[7:0]};
                f3_lh: result = {{16{shifted[15]}}, shifted[15:0]};
                f3_lbu: result = {24'h0, shifted[7:0]};
                f3_lhu: result = {16'h0, shifted[15:0]};
                default: result = shifted;
            endcase
        end
    end

    // one-entry register, free when empty or draining
    assign out_ready = !cdb_valid || cdb_ready;
    assign load_en = done_valid && out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            cdb_valid <= 1'b0;
        end else if (load_en) begin
            cdb_valid <= 1'b1;
        end else if (cdb_ready) begin
            cdb_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            cdb_rob <= done_rob;
            cdb_pd <= done_pd;
            cdb_data <= result;
            cdb_is_store <= done_is_store;
        end
    end

    a_cdb_hold: assert property (
        @(posedge clk) disable iff (rst)
        cdb_valid && !cdb_ready |=> cdb_valid && $stable(cdb_rob) && $stable(cdb_pd)
            && $stable(cdb_data) && $stable(cdb_is_store)
    );

endmodule

// File: lsu_top.sv
`timescale 1ns/1ps

module lsu_top
    import lsu_pkg::*;
#(
    parameter int QUEUE_DEPTH = MEM_QUEUE_DEPTH,
    parameter int MEM_WORDS = lsu_pkg::MEM_WORDS,
    localparam int IDX_BITS = $clog2(QUEUE_DEPTH)
) (
    input  logic                clk,
    input  logic                rst,

    input  logic                disp_valid,
    output logic                disp_ready,
    input  logic                disp_is_store,
    input  funct3_t             disp_funct3,
    input  rob_tag_t            disp_rob,
    input  preg_t               disp_pd,
    output logic [IDX_BITS-1:0] disp_idx,

    input  logic                agu_valid,
    input  logic [IDX_BITS-1:0] agu_idx,
    input  word_t               agu_base,
    input  word_t               agu_offset,
    input  word_t               agu_wdata,

    input  logic                commit_valid,
    input  rob_tag_t            commit_rob,

    output logic                cdb_valid,
    input  logic                cdb_ready,
    output rob_tag_t            cdb_rob,
    output preg_t               cdb_pd,
    output word_t               cdb_data,
    output logic                cdb_is_store
);

    logic addr_valid;
    logic [IDX_BITS-1:0] addr_idx;
    word_t addr;
    word_t addr_wdata;

    logic req_valid;
    word_t req_addr;
    mask_t req_rmask;
    mask_t req_wmask;
    word_t req_wdata;
    logic rsp_valid;
    word_t rsp_rdata;

    logic out_ready;
    logic done_valid;
    rob_tag_t done_rob;
    preg_t done_pd;
    logic done_is_store;
    funct3_t done_funct3;
    logic [1:0] done_offset;

    agu #(.QUEUE_DEPTH(QUEUE_DEPTH)) agu0 (.*);

    memory_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) queue0 (.*);

    data_mem #(.MEM_WORDS(MEM_WORDS)) mem0 (.*);

    load_align align0 (.*);

endmodule

// File: tb_lsu.sv
`timescale 1ns/1ps

module tb_lsu;
    import lsu_pkg::*;

    localparam int QUEUE_DEPTH = 8;
    localparam int IDX_BITS = $clog2(QUEUE_DEPTH);
    localparam int MAX_OPS = 32;

    logic clk;
    logic rst;
    logic disp_valid;
    logic disp_ready;
    logic disp_is_store;
    funct3_t disp_funct3;
    rob_tag_t disp_rob;
    preg_t disp_pd;
    logic [IDX_BITS-1:0] disp_idx;
    logic agu_valid;
    logic [IDX_BITS-1:0] agu_idx;
    word_t agu_base;
    word_t agu_offset;
    word_t agu_wdata;
    logic commit_valid;
    rob_tag_t commit_rob;
    logic cdb_valid;
    logic cdb_ready;
    rob_tag_t cdb_rob;
    preg_t cdb_pd;
    word_t cdb_data;
    logic cdb_is_store;

    logic op_store [MAX_OPS];
    funct3_t op_f3 [MAX_OPS];
    word_t op_base [MAX_OPS];
    word_t op_off [MAX_OPS];
    word_t op_wdata [MAX_OPS];
    word_t op_exp [MAX_OPS];
    logic [IDX_BITS-1:0] op_slot [MAX_OPS];
    logic committed [MAX_OPS];
    word_t model_mem [256];
    // dispatched ops still waiting for an address
    int pool [$];
    int n_ops = 0;
    int errors = 0;
    int passed = 0;
    int stalls = 0;
    int reorders = 0;
    int extras = 0;

    lsu_top #(.QUEUE_DEPTH(QUEUE_DEPTH), .MEM_WORDS(256)) dut0 (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic string op_name(int i);
        string m;
        if (op_store[i]) begin
            m = (op_f3[i] == f3_sb) ? "sb" : (op_f3[i] == f3_sh) ? "sh" : "sw";
        end else begin
            case (op_f3[i])
                f3_lb: m = "lb";
                f3_lh: m = "lh";
                f3_lbu: m = "lbu";
                f3_lhu: m = "lhu";
                default: m = "lw";
            endcase
        end
        return $sformatf("op%0d_%s", i, m);
    endfunction

    task automatic read_ops();
        int fd;
        string line;
        logic [31:0] c_kind;
        logic [31:0] c_f3;
        logic [31:0] c_base;
        logic [31:0] c_off;
        logic [31:0] c_data;
        fd = $fopen("lsu_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open lsu_input.txt");
            return;
        end
        // comment lines fail the scan and are skipped
        while (n_ops < MAX_OPS && $fgets(line, fd) != 0) begin
            if ($sscanf(line, "%h %h %h %h %h", c_kind, c_f3, c_base, c_off, c_data) == 5) begin
                op_store[n_ops] = c_kind[0];
                op_f3[n_ops] = c_f3[2:0];
                op_base[n_ops] = c_base;
                op_off[n_ops] = c_off;
                op_wdata[n_ops] = c_data;
                n_ops++;
            end
        end
        $fclose(fd);
    endtask

    // program order walk over a byte lane model of memory
    function automatic void build_expected();
        word_t a;
        word_t w;
        word_t sh;
        int s;
        foreach (model_mem[k]) model_mem[k] = '0;
        for (int i = 0; i < n_ops; i++) begin
            a = op_base[i] + op_off[i];
            s = 8 * int'(a[1:0]);
            w = model_mem[a[9:2]];
            sh = w >> s;
            op_exp[i] = '0;
            if (op_store[i]) begin
                case (op_f3[i])
                    f3_sb: w = (w & ~(32'hff << s)) | ((op_wdata[i] & 32'hff) << s);
                    f3_sh: w = (w & ~(32'hffff << s)) | ((op_wdata[i] & 32'hffff) << s);
                    default: w = op_wdata[i];
                endcase
                model_mem[a[9:2]] = w;
            end else begin
                case (op_f3[i])
                    f3_lb: op_exp[i] = {{24{sh[7]}}, sh[7:0]};
                    f3_lh: op_exp[i] = {{16{sh[15]}}, sh[15:0]};
                    f3_lbu: op_exp[i] = {24'h0, sh[7:0]};
                    f3_lhu: op_exp[i] = {16'h0, sh[15:0]};
                    default: op_exp[i] = w;
                endcase
            end
        end
    endfunction

    task automatic dispatch_ops();
        logic taken;
        int slot_exp;
        for (int i = 0; i < n_ops; i++) begin
            disp_valid = 1'b1;
            disp_is_store = op_store[i];
            disp_funct3 = op_f3[i];
            disp_rob = rob_tag_t'(i);
            disp_pd = preg_t'(i + 16);
            taken = 1'b0;
            while (!taken) begin
                @(negedge clk);
                taken = disp_ready;
                op_slot[i] = disp_idx;
                if (!taken) stalls++;
                @(posedge clk);
            end
            pool.push_back(i);
            // circular queue fills slots in order starting from 0
            slot_exp = i % QUEUE_DEPTH;
            if (int'(op_slot[i]) != slot_exp) begin
                errors++;
                $display("MISMATCH %s slot: expected %0d actual %0d", op_name(i), slot_exp,
                         op_slot[i]);
            end
            #1;
        end
        disp_valid = 1'b0;
    endtask

    task automatic supply_addresses();
        int addressed;
        int pick;
        int op;
        int last;
        addressed = 0;
        last = -1;
        while (addressed < n_ops) begin
            agu_valid = 1'b0;
            if (pool.size() > 0 && $urandom_range(1) == 1) begin
                pick = int'($urandom_range(pool.size() - 1));
                op = pool[pick];
                pool.delete(pick);
                if (op < last) reorders++;
                last = op;
                agu_valid = 1'b1;
                agu_idx = op_slot[op];
                agu_base = op_base[op];
                agu_offset = op_off[op];
                agu_wdata = op_wdata[op];
                addressed++;
            end
            @(posedge clk);
            #1;
        end
        agu_valid = 1'b0;
    endtask

    // rob commits one op at a time, after the previous one shows up on the cdb
    task automatic drive_commits();
        logic seen;
        int gap;
        for (int k = 0; k < n_ops; k++) begin
            gap = int'($urandom_range(3));
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            commit_valid = 1'b1;
            commit_rob = rob_tag_t'(k);
            committed[k] = 1'b1;
            seen = 1'b0;
            while (!seen) begin
                @(negedge clk);
                seen = cdb_valid && (cdb_rob == rob_tag_t'(k));
                @(posedge clk);
                #1;
            end
            commit_valid = 1'b0;
        end
    endtask

    task automatic collect_completions();
        int done;
        string name;
        done = 0;
        while (done < n_ops) begin
            @(negedge clk);
            if (cdb_valid && cdb_ready) begin
                name = op_name(done);
                if (!committed[int'(cdb_rob)]) begin
                    errors++;
                    $display("%s: completion seen before its commit tag was driven", name);
                end else if (cdb_rob != rob_tag_t'(done)) begin
                    errors++;
                    $display("MISMATCH %s rob: expected %0d actual %0d", name, done, cdb_rob);
                end else if (cdb_pd != preg_t'(done + 16)) begin
                    errors++;
                    $display("MISMATCH %s pd: expected %0d actual %0d", name, done + 16, cdb_pd);
                end else if (cdb_is_store != op_store[done]) begin
                    errors++;
                    $display("MISMATCH %s is_store: expected %0b actual %0b", name,
                             op_store[done], cdb_is_store);
                end else if (cdb_data != op_exp[done]) begin
                    errors++;
                    $display("MISMATCH %s data: expected %08h actual %08h", name,
                             op_exp[done], cdb_data);
                end else begin
                    passed++;
                    $display("PASS %s", name);
                end
                done++;
            end
            @(posedge clk);
            #1;
            cdb_ready = ($urandom_range(3) != 0);
        end
        cdb_ready = 1'b1;
    endtask

    initial begin
        void'($urandom(84556));
        rst = 1'b1;
        disp_valid = 1'b0;
        disp_is_store = 1'b0;
        disp_funct3 = '0;
        disp_rob = '0;
        disp_pd = '0;
        agu_valid = 1'b0;
        agu_idx = '0;
        agu_base = '0;
        agu_offset = '0;
        agu_wdata = '0;
        commit_valid = 1'b0;
        commit_rob = '0;
        cdb_ready = 1'b1;
        foreach (committed[i]) committed[i] = 1'b0;
        read_ops();
        build_expected();
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        if (disp_ready || cdb_valid) begin
            errors++;
            $display("reset: disp_ready or cdb_valid is high in the first cycle after reset");
        end else begin
            passed++;
            $display("PASS reset");
        end
        @(posedge clk);
        #1;
        if (n_ops == 0) begin
            errors++;
            $display("no operations were read from lsu_input.txt");
        end else begin
            fork
                dispatch_ops();
                supply_addresses();
                drive_commits();
                collect_completions();
            join
        end
        if (n_ops > QUEUE_DEPTH && stalls == 0) begin
            errors++;
            $display("dispatch never stalled although the list is longer than the queue");
        end
        if (n_ops > 2 && reorders == 0) begin
            errors++;
            $display("addresses were never supplied out of program order");
        end
        // a duplicated completion would show up here
        repeat (4) begin
            @(negedge clk);
            if (cdb_valid) extras++;
        end
        if (extras != 0) begin
            errors++;
            $display("completion port stayed valid after the last operation");
        end
        $display("tests: %0d passed, %0d failed", passed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        // op list is fully read by the time reset is released
        @(negedge rst);
        wait (n_ops > 0);
        repeat (200 * n_ops) @(posedge clk);
        $display("timeout: operations still outstanding after %0d cycles", 200 * n_ops);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: lsu_input.txt
// kind (1 store, 0 load), funct3, base, offset, store data; all hex
// effective address is base + offset and is naturally aligned
1 2 00000100 00000000 deadbeef
0 2 000000f0 00000010 00000000
1 0 00000104 00000000 00000011
1 0 00000100 00000005 00000082
1 0 00000108 fffffffe 12345633
1 0 00000107 00000000 000000f4
0 2 00000108 fffffffc 00000000
1 1 00000108 00000000 00008765
1 1 00000100 0000000a abcd1234
0 2 00000100 00000008 00000000
1 0 0000010c 00000001 000000a5
0 2 0000010c 00000000 00000000
0 0 00000104 00000000 00000000
0 0 00000105 00000000 00000000
0 0 00000100 00000006 00000000
0 0 00000107 00000000 00000000
0 4 00000107 00000000 00000000
0 1 00000108 00000000 00000000
0 1 0000010a 00000000 00000000
0 5 00000108 00000000 00000000
0 1 00000102 00000000 00000000
0 5 00000100 00000000 00000000

// File: lsu.f
lsu_pkg.sv
agu.sv
memory_queue.sv
data_mem.sv
load_align.sv
lsu_top.sv
tb_lsu.sv

// File: Makefile
VERILATOR = verilator
TOP = tb_lsu
FILELIST = lsu.f
FLAGS = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only -Wall --timing
PASS_MSG = Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
